//--- include/icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// log2 of line size in bytes
`define ICACHE_LEN_LINE 6

// log2 of lines per way
`define ICACHE_LEN_INDEX 6

// physical tag, everything above the 4 KiB page offset
`define ICACHE_LEN_TAG 20

// words per line, also the refill burst length
`define ICACHE_NR_WORDS 16

// 8-byte instruction pairs per line
`define ICACHE_DW_PER_LINE 8

// unmapped segment bounds
`define ICACHE_KSEG0_BASE 32'h8000_0000
`define ICACHE_KSEG1_BASE 32'hA000_0000
`define ICACHE_KSEG2_BASE 32'hC000_0000

`endif

//--- verilog/icache_pkg.sv
`include "icache_consts.svh"

package icache_pkg;

    // address or instruction
    typedef logic [31:0] word_t;

    // one data array entry, an instruction pair
    typedef logic [63:0] dword_t;

    typedef logic [`ICACHE_LEN_TAG-1:0] tag_t;

    typedef logic [`ICACHE_LEN_INDEX-1:0] index_t;

    // virtual or physical page number
    typedef logic [19:0] page_t;

    // even/odd page pair
    typedef logic [18:0] vpn2_t;

    typedef enum logic [2:0] {
        IDLE,
        TLB_FILL,
        UNCACHED,
        CACHE_REPLACE,
        SAVE_RESULT
    } icache_state_t;

endpackage

//--- verilog/icache_itlb.sv
`include "icache_consts.svh"

module icache_itlb (
    input  logic                clk,
    input  logic                rst,
    input  icache_pkg::word_t   inst_va,
    input  logic                tlb_req,
    input  logic                tlb_flush,
    output icache_pkg::vpn2_t   itlb_vpn2,
    input  logic                itlb_found,
    input  logic                itlb_v0,
    input  logic                itlb_v1,
    input  logic                itlb_c0,
    input  logic                itlb_c1,
    input  icache_pkg::page_t   itlb_pfn0,
    input  icache_pkg::page_t   itlb_pfn1,
    output icache_pkg::tag_t    ptag,
    output logic                uncached,
    output logic                trans_ok,
    output logic                fault_refill,
    output logic                fault_invalid
);
    import icache_pkg::*;

    logic  entry_valid;
    page_t entry_vpn;
    page_t entry_ppn;
    logic  entry_uncached;

    page_t vpn;
    logic  direct;
    logic  odd;
    logic  sel_v;

    assign vpn = inst_va[31:12];
    // kseg0 and kseg1 bypass the TLB
    assign direct = (inst_va >= `ICACHE_KSEG0_BASE) && (inst_va < `ICACHE_KSEG2_BASE);

    assign ptag     = direct ? {3'b000, inst_va[28:12]} : entry_ppn;
    assign uncached = direct ? (inst_va >= `ICACHE_KSEG1_BASE) : entry_uncached;
    assign trans_ok = direct || (entry_valid && entry_vpn == vpn);

    // L2 lookup, odd page picks the second half
    assign itlb_vpn2 = inst_va[31:13];
    assign odd       = inst_va[12];
    assign sel_v     = odd ? itlb_v1 : itlb_v0;

    assign fault_refill  = tlb_req && !itlb_found;
    assign fault_invalid = tlb_req && itlb_found && !sel_v;

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= 1'b0;
        end else if (tlb_req && itlb_found && sel_v) begin
            entry_valid <= 1'b1;
        end else if (tlb_flush) begin
            entry_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_req && itlb_found && sel_v) begin
            entry_vpn      <= vpn;
            entry_ppn      <= odd ? itlb_pfn1 : itlb_pfn0;
            entry_uncached <= odd ? !itlb_c1 : !itlb_c0;
        end
    end

    a_fill_on_miss: assert property (@(posedge clk) disable iff (rst)
        tlb_req |-> !trans_ok);

endmodule

//--- verilog/icache_ways.sv
`include "icache_consts.svh"

module icache_ways (
    input  logic                clk,
    input  logic                rst,
    input  icache_pkg::word_t   rd_va,
    input  icache_pkg::word_t   line_va,
    input  logic                fill_start,
    input  icache_pkg::tag_t    fill_tag,
    input  logic                fill_beat,
    input  icache_pkg::word_t   fill_word,
    input  logic                fill_done,
    input  logic                touch,
    input  logic                touch_way,
    input  logic                inval,
    input  icache_pkg::word_t   inval_va,
    output icache_pkg::tag_t    tag0,
    output icache_pkg::tag_t    tag1,
    output icache_pkg::dword_t  data0,
    output icache_pkg::dword_t  data1,
    output logic [1:0]          valid,
    output logic                lru
);
    import icache_pkg::*;

    localparam int NR_LINES  = 1 << `ICACHE_LEN_INDEX;
    localparam int DEPTH     = NR_LINES * `ICACHE_DW_PER_LINE;
    localparam int LEN_DADDR = $clog2(DEPTH);
    localparam int LEN_BEAT  = $clog2(`ICACHE_NR_WORDS);

    logic [1:0] valid_mem [NR_LINES];
    logic       lru_mem [NR_LINES];

    index_t                line_idx;
    index_t                inval_idx;
    index_t                rd_idx;
    logic [LEN_DADDR-1:0]  rd_daddr;

    // refill bookkeeping
    logic                  filling;
    logic                  victim;
    index_t                fill_idx;
    logic [LEN_BEAT-1:0]   beat_cnt;
    logic [LEN_DADDR-1:0]  wr_daddr;
    logic [7:0]            wr_be;
    dword_t                fill_pair;

    tag_t   tag_q [2];
    dword_t data_q [2];

    assign line_idx  = line_va[`ICACHE_LEN_LINE +: `ICACHE_LEN_INDEX];
    assign inval_idx = inval_va[`ICACHE_LEN_LINE +: `ICACHE_LEN_INDEX];
    assign rd_idx    = rd_va[`ICACHE_LEN_LINE +: `ICACHE_LEN_INDEX];
    assign rd_daddr  = rd_va[3 +: LEN_DADDR];

    assign valid = valid_mem[line_idx];
    assign lru   = lru_mem[line_idx];

    // even beat fills the low word of the pair
    assign wr_daddr  = {fill_idx, beat_cnt[LEN_BEAT-1:1]};
    assign wr_be     = beat_cnt[0] ? 8'hf0 : 8'h0f;
    assign fill_pair = {fill_word, fill_word};

    for (genvar w = 0; w < 2; w++) begin : g_way
        tag_t   tag_mem [NR_LINES];
        dword_t data_mem [DEPTH];

        always_ff @(posedge clk) begin
            if (fill_start && lru == w) begin
                tag_mem[line_idx] <= fill_tag;
            end
            tag_q[w] <= tag_mem[rd_idx];
        end

        always_ff @(posedge clk) begin
            for (int b = 0; b < 8; b++) begin
                if (fill_beat && victim == w && wr_be[b]) begin
                    data_mem[wr_daddr][b*8 +: 8] <= fill_pair[b*8 +: 8];
                end
            end
            data_q[w] <= data_mem[rd_daddr];
        end
    end

    assign tag0  = tag_q[0];
    assign tag1  = tag_q[1];
    assign data0 = data_q[0];
    assign data1 = data_q[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_mem <= '{default: '0};
            lru_mem   <= '{default: '0};
            filling   <= 1'b0;
            victim    <= 1'b0;
            fill_idx  <= '0;
            beat_cnt  <= '0;
        end else begin
            if (fill_start) begin
                filling  <= 1'b1;
                victim   <= lru;
                fill_idx <= line_idx;
                beat_cnt <= '0;
                valid_mem[line_idx][lru] <= 1'b0;
            end
            if (fill_beat) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
            if (fill_done) begin
                filling <= 1'b0;
                valid_mem[fill_idx][victim] <= 1'b1;
            end
            if (touch) begin
                lru_mem[line_idx] <= ~touch_way;
            end
            if (inval) begin
                valid_mem[inval_idx] <= 2'b00;
            end
        end
    end

    a_beat_in_fill: assert property (@(posedge clk) disable iff (rst)
        fill_beat |-> filling);

endmodule

//--- verilog/icache_ctrl.sv
`include "icache_consts.svh"

module icache_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                inst_en,
    input  icache_pkg::word_t   inst_va,
    input  icache_pkg::word_t   inst_va_next,
    input  logic                stallF,
    input  logic                fence_i,
    input  icache_pkg::word_t   fence_addr,
    input  logic                fence_tlb,
    output icache_pkg::word_t   inst_rdata0,
    output icache_pkg::word_t   inst_rdata1,
    output logic                inst_ok0,
    output logic                inst_ok1,
    output logic                istall,
    output logic                inst_tlb_refill,
    output logic                inst_tlb_invalid,
    input  icache_pkg::tag_t    ptag,
    input  logic                uncached,
    input  logic                trans_ok,
    input  logic                fault_refill,
    input  logic                fault_invalid,
    output logic                tlb_req,
    output logic                tlb_flush,
    output icache_pkg::word_t   rd_va,
    output icache_pkg::word_t   line_va,
    output logic                fill_start,
    output icache_pkg::tag_t    fill_tag,
    output logic                fill_beat,
    output icache_pkg::word_t   fill_word,
    output logic                fill_done,
    output logic                touch,
    output logic                touch_way,
    output logic                inval,
    output icache_pkg::word_t   inval_va,
    input  icache_pkg::tag_t    tag0,
    input  icache_pkg::tag_t    tag1,
    input  icache_pkg::dword_t  data0,
    input  icache_pkg::dword_t  data1,
    input  logic [1:0]          valid,
    input  logic                lru,
    output icache_pkg::word_t   araddr,
    output logic [7:0]          arlen,
    output logic [2:0]          arsize,
    output logic                arvalid,
    input  logic                arready,
    input  icache_pkg::word_t   rdata,
    input  logic                rlast,
    input  logic                rvalid,
    output logic                rready
);
    import icache_pkg::*;

    icache_state_t state;

    logic   hit0;
    logic   hit1;
    logic   hit_ok;
    logic   idle;
    dword_t pair;
    word_t  saved_inst0;
    logic   saved_ok0;
    logic   beat;

    assign idle   = state == IDLE;
    assign hit0   = valid[0] && tag0 == ptag;
    assign hit1   = valid[1] && tag1 == ptag;
    assign hit_ok = (hit0 || hit1) && trans_ok && !uncached;
    assign pair   = hit1 ? data1 : data0;

    assign istall = idle ? (inst_en && !hit_ok) : (state != SAVE_RESULT);

    assign inst_ok0    = (idle ? hit_ok : saved_ok0) && inst_en;
    assign inst_ok1    = idle && hit_ok && !inst_va[2] && inst_en;
    assign inst_rdata0 = idle ? (inst_va[2] ? pair[63:32] : pair[31:0]) : saved_inst0;
    assign inst_rdata1 = pair[63:32];

    // arrays must be pointed at the next fetch while the pipeline can move
    assign rd_va   = (idle || state == SAVE_RESULT) ? inst_va_next : inst_va;
    assign line_va = inst_va;

    assign tlb_req   = state == TLB_FILL;
    assign tlb_flush = fence_tlb && !istall;
    assign inval     = fence_i && !istall;
    assign inval_va  = fence_addr;

    // only needed when the hitting way is still the LRU one
    assign touch     = idle && inst_en && hit_ok && !stallF && (hit1 == lru);
    assign touch_way = hit1;

    assign fill_start = idle && inst_en && trans_ok && !uncached && !(hit0 || hit1);
    assign fill_tag   = ptag;
    assign beat       = rvalid && rready;
    assign fill_beat  = state == CACHE_REPLACE && beat;
    assign fill_word  = rdata;
    assign fill_done  = fill_beat && rlast;

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= IDLE;
            arvalid          <= 1'b0;
            rready           <= 1'b0;
            saved_ok0        <= 1'b0;
            inst_tlb_refill  <= 1'b0;
            inst_tlb_invalid <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                arvalid <= 1'b0;
                rready  <= 1'b1;
            end
            case (state)
                IDLE: begin
                    if (inst_en && !trans_ok) begin
                        state <= TLB_FILL;
                    end else if (inst_en && uncached) begin
                        arvalid <= 1'b1;
                        state   <= UNCACHED;
                    end else if (fill_start) begin
                        arvalid <= 1'b1;
                        state   <= CACHE_REPLACE;
                    end
                end
                TLB_FILL: begin
                    if (fault_refill || fault_invalid) begin
                        inst_tlb_refill  <= fault_refill;
                        inst_tlb_invalid <= fault_invalid;
                        saved_ok0        <= 1'b1;
                        state            <= SAVE_RESULT;
                    end else begin
                        state <= IDLE;
                    end
                end
                UNCACHED: begin
                    if (beat) begin
                        rready    <= 1'b0;
                        saved_ok0 <= 1'b1;
                        state     <= SAVE_RESULT;
                    end
                end
                CACHE_REPLACE: begin
                    if (beat && rlast) begin
                        rready <= 1'b0;
                    end else if (!arvalid && !rready) begin
                        // last beat now written, re-evaluate in IDLE
                        state <= IDLE;
                    end
                end
                SAVE_RESULT: begin
                    if (!stallF) begin
                        saved_ok0        <= 1'b0;
                        inst_tlb_refill  <= 1'b0;
                        inst_tlb_invalid <= 1'b0;
                        state            <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (idle && inst_en && trans_ok && uncached) begin
            araddr <= {ptag, inst_va[11:0]};
            arlen  <= 8'd0;
            arsize <= 3'd2;
        end else if (fill_start) begin
            araddr <= {ptag, inst_va[11:`ICACHE_LEN_LINE], {`ICACHE_LEN_LINE{1'b0}}};
            arlen  <= 8'(`ICACHE_NR_WORDS - 1);
            arsize <= 3'd2;
        end
        if (state == TLB_FILL) begin
            saved_inst0 <= '0;
        end else if (state == UNCACHED && beat) begin
            saved_inst0 <= rdata;
        end
    end

    a_one_way_hit: assert property (@(posedge clk) disable iff (rst)
        !(hit0 && hit1));

    a_addr_before_data: assert property (@(posedge clk) disable iff (rst)
        arvalid |-> !rready);

endmodule

//--- verilog/icache_top.sv
module icache_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                inst_en,
    input  icache_pkg::word_t   inst_va,
    input  icache_pkg::word_t   inst_va_next,
    input  logic                stallF,
    input  logic                fence_i,
    input  icache_pkg::word_t   fence_addr,
    input  logic                fence_tlb,
    output icache_pkg::word_t   inst_rdata0,
    output icache_pkg::word_t   inst_rdata1,
    output logic                inst_ok0,
    output logic                inst_ok1,
    output logic                istall,
    output logic                inst_tlb_refill,
    output logic                inst_tlb_invalid,
    output icache_pkg::vpn2_t   itlb_vpn2,
    input  logic                itlb_found,
    input  logic                itlb_v0,
    input  logic                itlb_v1,
    input  logic                itlb_c0,
    input  logic                itlb_c1,
    input  icache_pkg::page_t   itlb_pfn0,
    input  icache_pkg::page_t   itlb_pfn1,
    output icache_pkg::word_t   araddr,
    output logic [7:0]          arlen,
    output logic [2:0]          arsize,
    output logic                arvalid,
    input  logic                arready,
    input  icache_pkg::word_t   rdata,
    input  logic                rlast,
    input  logic                rvalid,
    output logic                rready
);
    import icache_pkg::*;

    // translation
    tag_t   ptag;
    logic   uncached;
    logic   trans_ok;
    logic   fault_refill;
    logic   fault_invalid;
    logic   tlb_req;
    logic   tlb_flush;

    // way store
    word_t  rd_va;
    word_t  line_va;
    logic   fill_start;
    tag_t   fill_tag;
    logic   fill_beat;
    word_t  fill_word;
    logic   fill_done;
    logic   touch;
    logic   touch_way;
    logic   inval;
    word_t  inval_va;
    tag_t   tag0;
    tag_t   tag1;
    dword_t data0;
    dword_t data1;
    logic [1:0] valid;
    logic   lru;

    icache_itlb u_itlb (.*);

    icache_ways u_ways (.*);

    icache_ctrl u_ctrl (.*);

endmodule

//--- sim/icache_tb.sv
module icache_tb;
    import icache_pkg::*;

    localparam int MAX_CASES = 64;
    localparam int FIELDS    = 8;

    logic       clk;
    logic       rst;
    logic       inst_en;
    logic       stallF;
    word_t      inst_va;
    word_t      inst_va_next;
    logic       fence_i;
    logic       fence_tlb;
    word_t      fence_addr;
    word_t      inst_rdata0;
    word_t      inst_rdata1;
    logic       inst_ok0;
    logic       inst_ok1;
    logic       istall;
    logic       inst_tlb_refill;
    logic       inst_tlb_invalid;
    vpn2_t      itlb_vpn2;
    logic       itlb_found;
    logic       itlb_v0;
    logic       itlb_v1;
    logic       itlb_c0;
    logic       itlb_c1;
    page_t      itlb_pfn0;
    page_t      itlb_pfn1;
    word_t      araddr;
    logic [7:0] arlen;
    logic [2:0] arsize;
    logic       arvalid;
    logic       arready;
    word_t      rdata;
    logic       rlast;
    logic       rvalid;
    logic       rready;

    word_t      cases [MAX_CASES*FIELDS];
    int         n_cases;
    int         limit = 0;
    int         cycles = 0;
    int         seed = 20593;
    word_t      cur_va;
    logic       cur_found;
    logic       cur_valid;
    logic       cur_cached;
    page_t      cur_pfn;

    // last read request seen by the memory model
    int         ar_count;
    word_t      ar_addr;
    logic [7:0] ar_len;
    logic [2:0] ar_size;

    icache_top uut (.*);

    always #2 clk = ~clk;

    // L2 TLB
    // the half not addressed gets the opposite valid and cached bits and another frame
    assign itlb_found = cur_found && itlb_vpn2 == cur_va[31:13];
    assign itlb_v0    = cur_va[12] ? !cur_valid : cur_valid;
    assign itlb_v1    = cur_va[12] ? cur_valid : !cur_valid;
    assign itlb_pfn0  = cur_va[12] ? ~cur_pfn : cur_pfn;
    assign itlb_pfn1  = cur_va[12] ? cur_pfn : ~cur_pfn;
    assign itlb_c0    = cur_va[12] ? !cur_cached : cur_cached;
    assign itlb_c1    = cur_va[12] ? cur_cached : !cur_cached;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic word_t mem_word(input word_t pa);
        return pa ^ 32'hc0de_0000;
    endfunction

    // kseg0 and kseg1 drop the top three bits, everything else uses the frame
    function automatic word_t phys_addr(input word_t va, input page_t pfn);
        if (va[31:30] == 2'b10) begin
            return {3'b000, va[28:0]};
        end
        return {pfn, va[11:0]};
    endfunction

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic fetch(input word_t va, input int exp_axi, input int exp_fault);
        word_t pa;
        logic  unc;
        logic  exp_ok1;
        pa      = phys_addr(va, cur_pfn);
        unc     = va[31:29] == 3'b101 || (va[31:30] != 2'b10 && !cur_cached);
        exp_ok1 = exp_fault == 0 && !unc && !va[2];
        ar_count     = 0;
        inst_va      = va;
        inst_va_next = va;
        @(posedge clk);
        #1;
        inst_en = 1'b1;
        do begin
            @(negedge clk);
        end while (istall || !inst_ok0);
        check(ar_count, (exp_axi == 0) ? 0 : 1, "number of AXI reads");
        if (exp_axi == 1) begin
            check(ar_addr, pa, "uncached araddr");
            check(ar_len, 0, "uncached arlen");
        end else if (exp_axi == 2) begin
            check(ar_addr, {pa[31:6], 6'b0}, "line araddr");
            check(ar_len, 15, "line arlen");
        end
        if (exp_axi != 0) begin
            check(ar_size, 2, "arsize");
        end
        check(inst_tlb_refill, exp_fault == 1, "inst_tlb_refill");
        check(inst_tlb_invalid, exp_fault == 2, "inst_tlb_invalid");
        check(inst_ok1, exp_ok1, "inst_ok1");
        check(inst_rdata0, (exp_fault != 0) ? 0 : mem_word(pa), "inst_rdata0");
        if (exp_ok1) begin
            check(inst_rdata1, mem_word(pa + 4), "inst_rdata1");
        end
        @(posedge clk);
        #1;
        inst_en = 1'b0;
    endtask

    task automatic apply_fence(input word_t op, input word_t va);
        fence_addr = va;
        fence_i    = op == 1;
        fence_tlb  = op == 2;
        @(negedge clk);
        check(istall, 0, "istall during a fence");
        @(posedge clk);
        #1;
        fence_i   = 1'b0;
        fence_tlb = 1'b0;
    endtask

    // memory, random wait before arready and before every beat
    initial begin : axi_mem
        word_t base;
        int    len;
        int    d;
        forever begin
            @(negedge clk);
            if (arvalid && !rst) begin
                base     = araddr;
                len      = arlen;
                ar_count = ar_count + 1;
                ar_addr  = araddr;
                ar_len   = arlen;
                ar_size  = arsize;
                d = $unsigned($random(seed)) % 4;
                repeat (d + 1) @(posedge clk);
                #1;
                arready = 1'b1;
                @(posedge clk);
                #1;
                arready = 1'b0;
                for (int i = 0; i <= len; i++) begin
                    d = $unsigned($random(seed)) % 4;
                    repeat (d) begin
                        @(posedge clk);
                        #1;
                    end
                    rvalid = 1'b1;
                    rdata  = mem_word(base + 4 * i);
                    rlast  = i == len;
                    do begin
                        @(negedge clk);
                    end while (!rready);
                    @(posedge clk);
                    #1;
                    rvalid = 1'b0;
                    rlast  = 1'b0;
                end
            end
        end
    end

    initial begin : run
        word_t op;
        clk          = 1'b0;
        rst          = 1'b1;
        inst_en      = 1'b0;
        stallF       = 1'b0;
        inst_va      = '0;
        inst_va_next = '0;
        fence_i      = 1'b0;
        fence_tlb    = 1'b0;
        fence_addr   = '0;
        arready      = 1'b0;
        rdata        = '0;
        rlast        = 1'b0;
        rvalid       = 1'b0;
        cur_va       = '0;
        cur_found    = 1'b0;
        cur_valid    = 1'b0;
        cur_cached   = 1'b0;
        cur_pfn      = '0;
        ar_count     = 0;
        for (int k = 0; k < MAX_CASES * FIELDS; k++) begin
            cases[k] = '1;
        end
        $readmemh("sim/icache_cases.txt", cases);
        n_cases = 0;
        while (n_cases < MAX_CASES && cases[n_cases * FIELDS] != '1) begin
            n_cases++;
        end
        if (n_cases == 0) begin
            $display("no cases could be read from sim/icache_cases.txt");
            $display("SIMULATION FAILED");
            $fatal(1, "empty case file");
        end
        limit = n_cases * 200;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check(arvalid, 0, "arvalid after reset");
        check(rready, 0, "rready after reset");
        check(istall, 0, "istall after reset");
        check(inst_ok0, 0, "inst_ok0 after reset");
        check(inst_ok1, 0, "inst_ok1 after reset");
        check(inst_tlb_refill, 0, "inst_tlb_refill after reset");
        check(inst_tlb_invalid, 0, "inst_tlb_invalid after reset");
        @(posedge clk);
        #1;
        for (int c = 0; c < n_cases; c++) begin
            op         = cases[c * FIELDS];
            cur_va     = cases[c * FIELDS + 1];
            cur_found  = cases[c * FIELDS + 2][0];
            cur_valid  = cases[c * FIELDS + 3][0];
            cur_pfn    = cases[c * FIELDS + 4][19:0];
            cur_cached = cases[c * FIELDS + 5][0];
            if (op == 0) begin
                fetch(cur_va, cases[c * FIELDS + 6], cases[c * FIELDS + 7]);
            end else begin
                apply_fence(op, cur_va);
            end
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- sim/icache_cases.txt
// op (0 fetch, 1 fence_i, 2 fence_tlb)  va  found  valid  pfn  cached
// axi read expected (0 none, 1 single, 2 line burst)  fault (0 none, 1 refill, 2 invalid)
// op va       fd vl pfn   c  axi flt
0 80001000 0 0 00000 0 2 0
0 80001014 0 0 00000 0 0 0
0 80001038 0 0 00000 0 0 0
0 a0002004 0 0 00000 0 1 0
0 a0002004 0 0 00000 0 1 0
0 a0002008 0 0 00000 0 1 0
0 00403010 1 1 00123 1 2 0
0 00403018 1 1 00123 1 0 0
0 00404000 0 0 00000 0 0 1
0 00405008 1 0 00321 1 0 2
0 00407004 1 1 00456 0 1 0
1 80001000 0 0 00000 0 0 0
0 80001008 0 0 00000 0 2 0
0 00403014 1 1 00123 1 2 0
2 00000000 0 0 00000 0 0 0
0 00403010 1 1 00789 1 2 0
0 80011040 0 0 00000 0 2 0
0 80012044 0 0 00000 0 2 0
0 8001104c 0 0 00000 0 0 0
0 80013048 0 0 00000 0 2 0
0 80011040 0 0 00000 0 0 0
0 80012044 0 0 00000 0 2 0

//--- verilog.f
+incdir+include
verilog/icache_pkg.sv
verilog/icache_itlb.sv
verilog/icache_ways.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
sim/icache_tb.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --assert -Wno-fatal
TOP       := icache_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
